//--- ofdm_pkg.sv
`default_nettype none

package ofdm_pkg;

    localparam int SAMPLE_W = 12;
    localparam int TWIDDLE_W = 12;
    localparam int TW_SCALE = 2 ** (TWIDDLE_W - 1) - 1;   // 2047
    localparam real PI = 3.14159265358979;

    // imaginary part sits in the upper half
    typedef struct packed {
        logic signed [SAMPLE_W-1:0] im;
        logic signed [SAMPLE_W-1:0] re;
    } sample_t;

    typedef logic [9:0] sfn_t;
    typedef logic [4:0] subframe_t;
    typedef logic [3:0] symbol_t;
    typedef logic [4:0] cp_len_t;

    typedef struct packed {
        sfn_t      sfn;
        subframe_t subframe;
        symbol_t   symbol;
    } sym_meta_t;

    typedef struct packed {
        sym_meta_t meta;
        cp_len_t   cp_len;   // low bits of the input tuser
    } in_user_t;

    typedef struct packed {
        sym_meta_t meta;
        logic      pbch_symbol;
    } out_user_t;

    // returns {sin, cos} of 2*pi*idx/2**nfft, scaled and rounded
    function automatic logic [2*TWIDDLE_W-1:0] twiddle(input int idx, input int nfft);
        real angle;
        int c;
        int s;
        angle = 2.0 * PI * real'(idx) / real'(2 ** nfft);
        c = int'($cos(angle) * real'(TW_SCALE));
        s = int'($sin(angle) * real'(TW_SCALE));
        return {TWIDDLE_W'(s), TWIDDLE_W'(c)};
    endfunction

endpackage

`default_nettype wire

//--- sample_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module sample_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int  DEPTH     = 4
) (
    input  wire logic     clk_i,
    input  wire logic     reset_ni,
    input  wire logic     push_i,
    input  wire payload_t push_data_i,
    input  wire logic     pop_i,
    output payload_t      pop_data_o,
    output logic          empty_o,
    output logic          full_o
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic do_push;
    logic do_pop;

    assign empty_o = (count_q == '0);
    assign full_o = (count_q == CNT_W'(DEPTH));
    assign pop_data_o = mem[rd_ptr_q];   // head is visible before the pop
    assign do_push = push_i && !full_o;
    assign do_pop = pop_i && !empty_o;

    always_ff @(posedge clk_i) begin
        if (do_push) begin
            mem[wr_ptr_q] <= push_data_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (do_pop) begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10: count_q <= count_q + 1'b1;
                2'b01: count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    a_no_push_full: assert property (@(posedge clk_i) disable iff (!reset_ni)
        push_i |-> !full_o)
        else $error("push into a full FIFO");

    a_no_pop_empty: assert property (@(posedge clk_i) disable iff (!reset_ni)
        pop_i |-> !empty_o)
        else $error("pop from an empty FIFO");

endmodule

`default_nettype wire

//--- cp_stripper.sv
`timescale 1ns/1ps
`default_nettype none

module cp_stripper #(
    parameter int NFFT     = 4,
    parameter int IN_DEPTH = 4
) (
    input  wire logic                clk_i,
    input  wire logic                reset_ni,
    input  wire logic                fifo_empty_i,
    input  wire ofdm_pkg::sample_t   fifo_data_i,
    input  wire ofdm_pkg::in_user_t  fifo_user_i,
    input  wire logic                fifo_last_i,
    output logic                     fifo_pop_o,
    output logic                     bank_wr_o,
    output logic [NFFT:0]            bank_wr_addr_o,
    output ofdm_pkg::sample_t        bank_wr_data_o,
    output logic [1:0]               bank_full_o,
    input  wire logic [1:0]          bank_release_i,
    output logic                     meta_push_o,
    output ofdm_pkg::sym_meta_t      meta_data_o
);

    import ofdm_pkg::*;

    localparam int FFT_LEN = 2 ** NFFT;

    typedef enum logic [1:0] {S_SKIP_CP, S_STORE, S_SKIP_TAIL} state_t;

    state_t state_q;
    cp_len_t cp_cnt_q;
    logic [NFFT-1:0] wr_cnt_q;
    logic wr_bank_q;
    logic stall;
    logic wr_bank_of_data;

    // a single entry would let the credit loop halve the input rate
    initial begin
        assert (IN_DEPTH >= 2) else $error("input FIFO needs at least two entries");
    end

    // the write bank is only full when the engine still holds both banks
    assign stall = (state_q == S_STORE) && bank_full_o[wr_bank_q];
    assign fifo_pop_o = !fifo_empty_i && !stall;

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            state_q <= S_SKIP_CP;
            cp_cnt_q <= '0;
            wr_cnt_q <= '0;
            wr_bank_q <= 1'b0;
            bank_full_o <= '0;
            bank_wr_o <= 1'b0;
            meta_push_o <= 1'b0;
        end else begin
            bank_wr_o <= fifo_pop_o && (state_q == S_STORE);
            meta_push_o <= 1'b0;
            bank_full_o <= bank_full_o & ~bank_release_i;
            if (fifo_pop_o) begin
                case (state_q)
                    S_SKIP_CP: begin
                        if (cp_cnt_q == fifo_user_i.cp_len - 1'b1) begin
                            cp_cnt_q <= '0;
                            state_q <= S_STORE;
                        end else begin
                            cp_cnt_q <= cp_cnt_q + 1'b1;
                        end
                    end
                    S_STORE: begin
                        wr_cnt_q <= wr_cnt_q + 1'b1;   // wraps to zero after the last sample
                        if (wr_cnt_q == NFFT'(FFT_LEN - 1)) begin
                            bank_full_o[wr_bank_q] <= 1'b1;
                            meta_push_o <= 1'b1;
                            wr_bank_q <= ~wr_bank_q;
                            state_q <= fifo_last_i ? S_SKIP_CP : S_SKIP_TAIL;
                        end
                    end
                    default: begin
                        if (fifo_last_i) begin
                            state_q <= S_SKIP_CP;
                        end
                    end
                endcase
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (fifo_pop_o) begin
            bank_wr_addr_o <= {wr_bank_q, wr_cnt_q};
            bank_wr_data_o <= fifo_data_i;
            meta_data_o <= fifo_user_i.meta;
        end
    end

    assign wr_bank_of_data = bank_wr_addr_o[NFFT];

    // only the last sample of a symbol may land in a bank that is already marked full
    a_wr_not_full: assert property (@(posedge clk_i) disable iff (!reset_ni)
        bank_wr_o && bank_full_o[wr_bank_of_data] |->
            bank_wr_addr_o[NFFT-1:0] == NFFT'(FFT_LEN - 1))
        else $error("sample written into a full bank");

endmodule

`default_nettype wire

//--- dft_engine.sv
`timescale 1ns/1ps
`default_nettype none

module dft_engine #(
    parameter int NFFT = 4
) (
    input  wire logic               clk_i,
    input  wire logic               reset_ni,
    input  wire logic [1:0]         bank_full_i,
    output logic [NFFT:0]           bank_rd_addr_o,
    input  wire ofdm_pkg::sample_t  bank_rd_data_i,
    output logic [1:0]              bank_release_o,
    output logic                    bin_valid_o,
    output ofdm_pkg::sample_t       bin_data_o,
    input  wire logic               bin_stall_i
);

    import ofdm_pkg::*;

    localparam int FFT_LEN = 2 ** NFFT;
    localparam int PROD_W = 2 * SAMPLE_W + 1;
    localparam int ACC_W = PROD_W + NFFT;
    localparam int SHIFT = TWIDDLE_W - 1 + NFFT;

    logic [2*TWIDDLE_W-1:0] tw_rom [FFT_LEN];

    logic active_q;
    logic bank_q;
    logic [NFFT-1:0] pos_q;
    logic [NFFT:0] cnt_q;            // FFT_LEN reads plus two pipeline cycles
    logic rd_valid_q;
    logic prod_valid_q;
    logic [NFFT-1:0] k_bin;
    logic [2*NFFT-1:0] kn;
    logic [NFFT-1:0] tw_idx_q;
    logic signed [TWIDDLE_W-1:0] w_re;
    logic signed [TWIDDLE_W-1:0] w_im;
    logic signed [PROD_W-1:0] prod_re_d;
    logic signed [PROD_W-1:0] prod_im_d;
    logic signed [PROD_W-1:0] prod_re_q;
    logic signed [PROD_W-1:0] prod_im_q;
    logic signed [ACC_W-1:0] acc_re_q;
    logic signed [ACC_W-1:0] acc_im_q;
    logic signed [ACC_W-1:0] sum_re;
    logic signed [ACC_W-1:0] sum_im;
    logic signed [ACC_W-1:0] scaled_re;
    logic signed [ACC_W-1:0] scaled_im;
    logic bin_done;
    logic advance;

    initial begin
        for (int i = 0; i < FFT_LEN; i++) begin
            tw_rom[i] = twiddle(i, NFFT);
        end
    end

    // output position p holds bin (p + FFT_LEN/2) mod FFT_LEN
    assign k_bin = pos_q + NFFT'(FFT_LEN / 2);
    assign kn = k_bin * cnt_q[NFFT-1:0];
    assign bank_rd_addr_o = {bank_q, cnt_q[NFFT-1:0]};

    assign bin_done = active_q && (cnt_q == (NFFT + 1)'(FFT_LEN + 1));
    assign advance = !(bin_done && bin_valid_o && bin_stall_i);   // hold until the old bin leaves

    // multiply by the conjugate twiddle, x * (cos - j sin)
    always_comb begin
        w_re = tw_rom[tw_idx_q][TWIDDLE_W-1:0];
        w_im = tw_rom[tw_idx_q][2*TWIDDLE_W-1:TWIDDLE_W];
        prod_re_d = bank_rd_data_i.re * w_re + bank_rd_data_i.im * w_im;
        prod_im_d = bank_rd_data_i.im * w_re - bank_rd_data_i.re * w_im;
        sum_re = acc_re_q + prod_re_q;
        sum_im = acc_im_q + prod_im_q;
        scaled_re = sum_re >>> SHIFT;
        scaled_im = sum_im >>> SHIFT;
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            active_q <= 1'b0;
            bank_q <= 1'b0;
            pos_q <= '0;
            cnt_q <= '0;
            rd_valid_q <= 1'b0;
            prod_valid_q <= 1'b0;
            bin_valid_o <= 1'b0;
            bank_release_o <= '0;
        end else begin
            bank_release_o <= '0;
            if (bin_valid_o && !bin_stall_i) begin
                bin_valid_o <= 1'b0;
            end
            if (!active_q) begin
                cnt_q <= '0;
                if (bank_full_i[bank_q]) begin
                    active_q <= 1'b1;
                end
            end else if (advance) begin
                rd_valid_q <= (cnt_q < (NFFT + 1)'(FFT_LEN));
                prod_valid_q <= rd_valid_q;
                if (bin_done) begin
                    bin_valid_o <= 1'b1;
                    cnt_q <= '0;
                    pos_q <= pos_q + 1'b1;
                    if (pos_q == NFFT'(FFT_LEN - 1)) begin
                        active_q <= 1'b0;
                        bank_q <= ~bank_q;
                        bank_release_o[bank_q] <= 1'b1;
                    end
                end else begin
                    cnt_q <= cnt_q + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (advance) begin
            tw_idx_q <= kn[NFFT-1:0];          // (k * n) mod FFT_LEN
            prod_re_q <= prod_re_d;
            prod_im_q <= prod_im_d;
            if (bin_done || !active_q) begin
                acc_re_q <= '0;
                acc_im_q <= '0;
            end else if (prod_valid_q) begin
                acc_re_q <= sum_re;
                acc_im_q <= sum_im;
            end
            if (bin_done) begin
                bin_data_o.re <= scaled_re[SAMPLE_W-1:0];
                bin_data_o.im <= scaled_im[SAMPLE_W-1:0];
            end
        end
    end

endmodule

`default_nettype wire

//--- bin_selector.sv
`timescale 1ns/1ps
`default_nettype none

module bin_selector #(
    parameter int NFFT            = 4,
    parameter int BWP_LEN         = 12,
    parameter int SSS_LEN         = 8,
    parameter int SYMS_PER_SSB    = 4,
    parameter int OUT_CREDITS_MAX = 8
) (
    input  wire logic                 clk_i,
    input  wire logic                 reset_ni,
    input  wire logic                 bin_valid_i,
    input  wire ofdm_pkg::sample_t    bin_data_i,
    output logic                      bin_stall_o,
    input  wire logic                 meta_empty_i,
    input  wire ofdm_pkg::sym_meta_t  meta_data_i,
    output logic                      meta_pop_o,
    input  wire logic                 out_credit_i,
    output logic                      out_valid_o,
    output ofdm_pkg::sample_t         out_data_o,
    output ofdm_pkg::out_user_t       out_user_o,
    output logic                      out_last_o,
    output logic                      pbch_valid_o,
    output logic                      sss_valid_o
);

    import ofdm_pkg::*;

    localparam int FFT_LEN = 2 ** NFFT;
    localparam int WIN_FIRST = FFT_LEN / 2 - BWP_LEN / 2;
    localparam int WIN_LAST = WIN_FIRST + BWP_LEN - 1;
    localparam int SSS_FIRST = FFT_LEN / 2 - SSS_LEN / 2;
    localparam int SSS_LAST = SSS_FIRST + SSS_LEN - 1;
    localparam int SYM_W = (SYMS_PER_SSB > 1) ? $clog2(SYMS_PER_SSB) : 1;
    localparam int CRED_W = $clog2(OUT_CREDITS_MAX + 1);

    logic [NFFT-1:0] pos_q;
    logic [SYM_W-1:0] sym_q;          // symbol index within the SSB period
    logic [CRED_W-1:0] credits_q;
    sym_meta_t meta_q;
    sym_meta_t cur_meta;
    logic in_win;
    logic in_sss;
    logic accept;
    logic fwd;

    assign in_win = (int'(pos_q) >= WIN_FIRST) && (int'(pos_q) <= WIN_LAST);
    assign in_sss = (int'(pos_q) >= SSS_FIRST) && (int'(pos_q) <= SSS_LAST);

    // bins outside the window drain without a credit
    assign bin_stall_o = bin_valid_i && in_win && (credits_q == '0);
    assign accept = bin_valid_i && !bin_stall_o;
    assign fwd = accept && in_win;

    assign meta_pop_o = accept && (pos_q == '0) && !meta_empty_i;
    assign cur_meta = (pos_q == '0) ? meta_data_i : meta_q;

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            pos_q <= '0;
            sym_q <= '0;
            credits_q <= '0;
            out_valid_o <= 1'b0;
            out_last_o <= 1'b0;
            pbch_valid_o <= 1'b0;
            sss_valid_o <= 1'b0;
        end else begin
            credits_q <= credits_q + CRED_W'(out_credit_i) - CRED_W'(fwd);
            if (accept) begin
                pos_q <= pos_q + 1'b1;
                if (pos_q == NFFT'(FFT_LEN - 1)) begin
                    sym_q <= (sym_q == SYM_W'(SYMS_PER_SSB - 1)) ? '0 : sym_q + 1'b1;
                end
            end
            out_valid_o <= fwd;
            out_last_o <= fwd && (int'(pos_q) == WIN_LAST);
            pbch_valid_o <= fwd && (sym_q == '0);
            sss_valid_o <= fwd && in_sss && (sym_q == SYM_W'(1));
        end
    end

    always_ff @(posedge clk_i) begin
        if (meta_pop_o) begin
            meta_q <= meta_data_i;
        end
        if (fwd) begin
            out_data_o <= bin_data_i;
            out_user_o <= '{meta: cur_meta, pbch_symbol: (sym_q == '0)};
        end
    end

    // the sink never grants more than the counter can hold
    a_credit_limit: assert property (@(posedge clk_i) disable iff (!reset_ni)
        out_credit_i && !fwd |-> credits_q < CRED_W'(OUT_CREDITS_MAX))
        else $error("output credits above limit");

    a_meta_ready: assert property (@(posedge clk_i) disable iff (!reset_ni)
        accept && (pos_q == '0) |-> !meta_empty_i)
        else $error("first bin of a symbol without metadata");

endmodule

`default_nettype wire

//--- ofdm_demod_top.sv
`timescale 1ns/1ps
`default_nettype none

module ofdm_demod_top #(
    parameter int NFFT            = 4,
    parameter int BWP_LEN         = 12,
    parameter int SSS_LEN         = 8,
    parameter int SYMS_PER_SSB    = 4,
    parameter int IN_DEPTH        = 4,
    parameter int OUT_CREDITS_MAX = 8
) (
    input  wire logic                clk_i,
    input  wire logic                reset_ni,
    input  wire logic                in_valid_i,
    input  wire ofdm_pkg::sample_t   in_data_i,
    input  wire ofdm_pkg::in_user_t  in_user_i,
    input  wire logic                in_last_i,
    output logic                     in_credit_o,
    output logic                     out_valid_o,
    output ofdm_pkg::sample_t        out_data_o,
    output ofdm_pkg::out_user_t      out_user_o,
    output logic                     out_last_o,
    output logic                     pbch_valid_o,
    output logic                     sss_valid_o,
    input  wire logic                out_credit_i
);

    import ofdm_pkg::*;

    localparam int FFT_LEN = 2 ** NFFT;
    localparam int META_DEPTH = 4;     // two full banks plus the symbol in flight

    typedef struct packed {
        sample_t  data;
        in_user_t user;
        logic     last;
    } in_entry_t;

    in_entry_t in_entry;
    in_entry_t fifo_entry;
    logic fifo_empty;
    logic fifo_pop;
    logic bank_wr;
    logic [NFFT:0] bank_wr_addr;
    sample_t bank_wr_data;
    logic [1:0] bank_full;
    logic [1:0] bank_release;
    logic [NFFT:0] bank_rd_addr;
    sample_t bank_rd_data;
    logic meta_push;
    sym_meta_t meta_push_data;
    logic meta_pop;
    sym_meta_t meta_pop_data;
    logic meta_empty;
    logic bin_valid;
    sample_t bin_data;
    logic bin_stall;
    sample_t bank_mem [2 * FFT_LEN];   // bank 0 low half, bank 1 high half

    assign in_entry = '{data: in_data_i, user: in_user_i, last: in_last_i};
    assign in_credit_o = fifo_pop;      // each freed slot goes back to the source

    // source credits keep the input FIFO from overflowing
    sample_fifo #(.payload_t(in_entry_t), .DEPTH(IN_DEPTH)) i_in_fifo (
        .clk_i      (clk_i),
        .reset_ni   (reset_ni),
        .push_i     (in_valid_i),
        .push_data_i(in_entry),
        .pop_i      (fifo_pop),
        .pop_data_o (fifo_entry),
        .empty_o    (fifo_empty),
        .full_o     ()
    );

    cp_stripper #(.NFFT(NFFT), .IN_DEPTH(IN_DEPTH)) i_cp_stripper (
        .clk_i         (clk_i),
        .reset_ni      (reset_ni),
        .fifo_empty_i  (fifo_empty),
        .fifo_data_i   (fifo_entry.data),
        .fifo_user_i   (fifo_entry.user),
        .fifo_last_i   (fifo_entry.last),
        .fifo_pop_o    (fifo_pop),
        .bank_wr_o     (bank_wr),
        .bank_wr_addr_o(bank_wr_addr),
        .bank_wr_data_o(bank_wr_data),
        .bank_full_o   (bank_full),
        .bank_release_i(bank_release),
        .meta_push_o   (meta_push),
        .meta_data_o   (meta_push_data)
    );

    always_ff @(posedge clk_i) begin
        if (bank_wr) begin
            bank_mem[bank_wr_addr] <= bank_wr_data;
        end
        bank_rd_data <= bank_mem[bank_rd_addr];
    end

    dft_engine #(.NFFT(NFFT)) i_dft_engine (
        .clk_i         (clk_i),
        .reset_ni      (reset_ni),
        .bank_full_i   (bank_full),
        .bank_rd_addr_o(bank_rd_addr),
        .bank_rd_data_i(bank_rd_data),
        .bank_release_o(bank_release),
        .bin_valid_o   (bin_valid),
        .bin_data_o    (bin_data),
        .bin_stall_i   (bin_stall)
    );

    // at most one entry per bank is pending, so it never fills
    sample_fifo #(.payload_t(sym_meta_t), .DEPTH(META_DEPTH)) i_meta_fifo (
        .clk_i      (clk_i),
        .reset_ni   (reset_ni),
        .push_i     (meta_push),
        .push_data_i(meta_push_data),
        .pop_i      (meta_pop),
        .pop_data_o (meta_pop_data),
        .empty_o    (meta_empty),
        .full_o     ()
    );

    bin_selector #(
        .NFFT           (NFFT),
        .BWP_LEN        (BWP_LEN),
        .SSS_LEN        (SSS_LEN),
        .SYMS_PER_SSB   (SYMS_PER_SSB),
        .OUT_CREDITS_MAX(OUT_CREDITS_MAX)
    ) i_bin_selector (
        .clk_i       (clk_i),
        .reset_ni    (reset_ni),
        .bin_valid_i (bin_valid),
        .bin_data_i  (bin_data),
        .bin_stall_o (bin_stall),
        .meta_empty_i(meta_empty),
        .meta_data_i (meta_pop_data),
        .meta_pop_o  (meta_pop),
        .out_credit_i(out_credit_i),
        .out_valid_o (out_valid_o),
        .out_data_o  (out_data_o),
        .out_user_o  (out_user_o),
        .out_last_o  (out_last_o),
        .pbch_valid_o(pbch_valid_o),
        .sss_valid_o (sss_valid_o)
    );

endmodule

`default_nettype wire

//--- tb_ofdm_model.svh
`ifndef TB_OFDM_MODEL_SVH
`define TB_OFDM_MODEL_SVH

// 16-bit Fibonacci LFSR with taps 16, 14, 13 and 11
function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
endfunction

// one step per bit taken, lsb first
function automatic int rand_bits(input int n);
    int v;
    v = 0;
    for (int i = 0; i < n; i++) begin
        lfsr_q = lfsr_next(lfsr_q);
        v = v | (int'(lfsr_q[0]) << i);
    end
    return v;
endfunction

// integer DFT of one shifted-order position, X[k] = sum x[n] * exp(-j 2 pi k n / N)
function automatic sample_t ref_bin(input sample_t x [FFT_LEN], input int pos);
    int k;
    logic [2*TWIDDLE_W-1:0] tw;
    logic signed [TWIDDLE_W-1:0] c;
    logic signed [TWIDDLE_W-1:0] s;
    longint xr;
    longint xi;
    longint acc_re;
    longint acc_im;
    sample_t y;
    k = (pos + FFT_LEN / 2) % FFT_LEN;
    acc_re = 0;
    acc_im = 0;
    for (int n = 0; n < FFT_LEN; n++) begin
        tw = twiddle((k * n) % FFT_LEN, NFFT);
        c = tw[TWIDDLE_W-1:0];
        s = tw[2*TWIDDLE_W-1:TWIDDLE_W];
        xr = longint'(x[n].re);
        xi = longint'(x[n].im);
        acc_re += xr * longint'(c) + xi * longint'(s);
        acc_im += xi * longint'(c) - xr * longint'(s);
    end
    acc_re = acc_re >>> (TWIDDLE_W - 1 + NFFT);
    acc_im = acc_im >>> (TWIDDLE_W - 1 + NFFT);
    y.re = acc_re[SAMPLE_W-1:0];   // wraps like a 12 bit register
    y.im = acc_im[SAMPLE_W-1:0];
    return y;
endfunction

// bins of the central window with their flags, in output order
task automatic queue_expected(input sample_t x [FFT_LEN], input sym_meta_t meta,
                              input int sym_idx);
    int ssb_pos;
    out_user_t u;
    ssb_pos = sym_idx % SYMS_PER_SSB;
    u.meta = meta;
    u.pbch_symbol = (ssb_pos == 0);
    for (int p = WIN_FIRST; p < WIN_FIRST + BWP_LEN; p++) begin
        exp_data.push_back(ref_bin(x, p));
        exp_user.push_back(u);
        exp_flags.push_back({p == WIN_FIRST + BWP_LEN - 1, ssb_pos == 0,
                             ssb_pos == 1 && p >= SSS_FIRST && p < SSS_FIRST + SSS_LEN});
    end
endtask

task automatic check(input int cat, input longint got, input longint exp, input string msg);
    checks[cat]++;
    if (got !== exp) begin
        errors[cat]++;
        $display("** Error at %0t ns: %s, got %0h, expected %0h", $time, msg, got, exp);
    end
endtask

`endif

//--- tb_ofdm_demod.sv
`timescale 1ns/1ps
`default_nettype none

module tb_ofdm_demod;

    import ofdm_pkg::*;

    localparam int NFFT = 4;
    localparam int FFT_LEN = 2 ** NFFT;
    localparam int BWP_LEN = 12;
    localparam int SSS_LEN = 8;
    localparam int SYMS_PER_SSB = 4;
    localparam int IN_DEPTH = 4;
    localparam int OUT_CREDITS_MAX = 8;
    localparam int CLK_PERIOD = 10;
    localparam int NUM_SYMS = 20;
    localparam int TOTAL_BEATS = NUM_SYMS * BWP_LEN;
    localparam int TIMEOUT_CYCLES = NUM_SYMS * (FFT_LEN * (FFT_LEN + 2) + 30) * 4;
    localparam int WIN_FIRST = FFT_LEN / 2 - BWP_LEN / 2;
    localparam int SSS_FIRST = FFT_LEN / 2 - SSS_LEN / 2;
    localparam int NUM_CATS = 6;

    logic clk_i;
    logic reset_ni;
    logic in_valid_i;
    sample_t in_data_i;
    in_user_t in_user_i;
    logic in_last_i;
    logic in_credit_o;
    logic out_valid_o;
    sample_t out_data_o;
    out_user_t out_user_o;
    logic out_last_o;
    logic pbch_valid_o;
    logic sss_valid_o;
    logic out_credit_i;

    sample_t stream_data [$];
    in_user_t stream_user [$];
    logic stream_last [$];
    sample_t exp_data [$];
    out_user_t exp_user [$];
    logic [2:0] exp_flags [$];      // last, pbch, sss

    logic [15:0] lfsr_q;
    int checks [NUM_CATS];
    int errors [NUM_CATS];
    string cat_names [NUM_CATS];
    int src_credits;
    int granted;
    int beats;
    int bins_in_sym;
    logic sym_bad;
    int total_checks;
    int total_errors;

    `include "tb_ofdm_model.svh"

    ofdm_demod_top #(
        .NFFT           (NFFT),
        .BWP_LEN        (BWP_LEN),
        .SSS_LEN        (SSS_LEN),
        .SYMS_PER_SSB   (SYMS_PER_SSB),
        .IN_DEPTH       (IN_DEPTH),
        .OUT_CREDITS_MAX(OUT_CREDITS_MAX)
    ) i_ofdm_demod_top (
        .clk_i       (clk_i),
        .reset_ni    (reset_ni),
        .in_valid_i  (in_valid_i),
        .in_data_i   (in_data_i),
        .in_user_i   (in_user_i),
        .in_last_i   (in_last_i),
        .in_credit_o (in_credit_o),
        .out_valid_o (out_valid_o),
        .out_data_o  (out_data_o),
        .out_user_o  (out_user_o),
        .out_last_o  (out_last_o),
        .pbch_valid_o(pbch_valid_o),
        .sss_valid_o (sss_valid_o),
        .out_credit_i(out_credit_i)
    );

    // each symbol is prefix, FFT_LEN useful samples, then 0 to 3 tail samples
    task automatic build_stimulus();
        sample_t x [FFT_LEN];
        sample_t smp;
        in_user_t user;
        int cp;
        int tail;
        for (int s = 0; s < NUM_SYMS; s++) begin
            user.meta.sfn = 10'(rand_bits(10));
            user.meta.subframe = 5'(rand_bits(5));
            user.meta.symbol = 4'(rand_bits(4));
            cp = rand_bits(3) % 7 + 1;
            tail = rand_bits(2);
            user.cp_len = 5'(cp);
            for (int i = 0; i < cp + FFT_LEN + tail; i++) begin
                smp = 24'(rand_bits(24));
                if (i >= cp && i < cp + FFT_LEN) begin
                    x[i - cp] = smp;
                end
                stream_data.push_back(smp);
                stream_user.push_back(user);
                stream_last.push_back(i == cp + FFT_LEN + tail - 1);
            end
            queue_expected(x, user.meta, s);
        end
    endtask

    task automatic score_outputs();
        sample_t e_data;
        out_user_t e_user;
        logic [2:0] e_flags;
        if (out_valid_o) begin
            beats++;
            bins_in_sym++;
            check(5, beats <= granted, 1, "output beat without a granted credit");
            if (exp_data.size() == 0) begin
                check(2, 1, 0, "output beat with no bin expected");
            end else begin
                e_data = exp_data.pop_front();
                e_user = exp_user.pop_front();
                e_flags = exp_flags.pop_front();
                check(1, out_data_o, e_data, "bin value");
                if (out_data_o !== e_data) begin
                    sym_bad = 1'b1;
                end
                check(2, out_last_o, e_flags[2], "last flag");
                check(3, pbch_valid_o, e_flags[1], "pbch flag");
                check(3, sss_valid_o, e_flags[0], "sss flag");
                check(3, out_user_o.pbch_symbol, e_user.pbch_symbol, "pbch_symbol bit");
                check(4, out_user_o.meta, e_user.meta, "symbol metadata");
                if (e_flags[2]) begin
                    check(0, sym_bad, 0, "stored symbol content");
                    sym_bad = 1'b0;
                end
            end
            if (out_last_o) begin
                check(2, bins_in_sym, BWP_LEN, "bins per symbol");
                bins_in_sym = 0;
            end
        end else if (out_last_o || pbch_valid_o || sss_valid_o) begin
            check(3, 1, 0, "flag raised without a valid beat");
        end
    endtask

    // a returned credit becomes usable only after the pop has happened
    task automatic drive_source();
        logic credit_back;
        credit_back = in_credit_o;
        if (src_credits > 0 && stream_data.size() > 0) begin
            in_valid_i = 1'b1;
            in_data_i = stream_data.pop_front();
            in_user_i = stream_user.pop_front();
            in_last_i = stream_last.pop_front();
            src_credits--;
        end else begin
            in_valid_i = 1'b0;
        end
        if (credit_back) begin
            src_credits++;
            check(5, src_credits <= IN_DEPTH, 1, "source credits above FIFO depth");
        end
    endtask

    task automatic drive_sink();
        logic want;
        want = rand_bits(1) != 0;
        if (want && (granted - beats) < OUT_CREDITS_MAX) begin   // counter limit in the DUT
            out_credit_i = 1'b1;
            granted++;
        end else begin
            out_credit_i = 1'b0;
        end
    endtask

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    initial begin
        wait (reset_ni === 1'b1);
        forever begin
            @(negedge clk_i);
            score_outputs();
            drive_source();
            drive_sink();
        end
    end

    initial begin
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        $display("timeout: not all bins came out within %0d cycles, %0d of %0d seen",
                 TIMEOUT_CYCLES, beats, TOTAL_BEATS);
        $display("Result: FAILED");
        $finish;
    end

    initial begin
        cat_names[0] = "prefix and tail removal";
        cat_names[1] = "transform values";
        cat_names[2] = "windowing";
        cat_names[3] = "pbch and sss flags";
        cat_names[4] = "metadata";
        cat_names[5] = "credits";
        reset_ni = 1'b0;
        in_valid_i = 1'b0;
        in_data_i = '0;
        in_user_i = '0;
        in_last_i = 1'b0;
        out_credit_i = 1'b0;
        lfsr_q = 16'd18;
        src_credits = IN_DEPTH;
        granted = 0;
        beats = 0;
        bins_in_sym = 0;
        sym_bad = 1'b0;
        total_checks = 0;
        total_errors = 0;
        for (int i = 0; i < NUM_CATS; i++) begin
            checks[i] = 0;
            errors[i] = 0;
        end
        build_stimulus();
        repeat (4) @(negedge clk_i);
        reset_ni = 1'b1;

        wait (beats >= TOTAL_BEATS);
        repeat (20) @(negedge clk_i);   // catch extra beats and late credits
        check(2, beats, TOTAL_BEATS, "total output beats");
        check(0, stream_data.size(), 0, "input stream fully sent");
        check(5, src_credits, IN_DEPTH, "source credits returned at the end");

        for (int i = 0; i < NUM_CATS; i++) begin
            $display("%s: %0d checks, %0d errors", cat_names[i], checks[i], errors[i]);
            total_checks += checks[i];
            total_errors += errors[i];
        end
        $display("total: %0d checks, %0d errors, %0d beats, %0d credits granted",
                 total_checks, total_errors, beats, granted);
        if (total_errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- compile.f
+incdir+.
ofdm_pkg.sv
sample_fifo.sv
cp_stripper.sv
dft_engine.sv
bin_selector.sv
ofdm_demod_top.sv
tb_ofdm_demod.sv

//--- run_sim.sh
#!/bin/sh
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_ofdm_demod -f compile.f \
    && ./obj_dir/Vtb_ofdm_demod > sim.log 2>&1 \
    || echo "build or simulation stopped early"
cat sim.log 2>/dev/null
grep -q "Result: PASSED" sim.log && echo "simulation passed" && exit 0 \
    || { echo "simulation failed"; exit 1; }
